/* hdl/uart_dbg_pkg.sv */
/*
  Shared protocol definitions for the UART debug server.
  Byte codes of the host protocol, field sizes and the common data types.
  Modules import this package wherever they use its names.
*/
`default_nettype none

package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  // One serial data byte
  typedef logic [7:0] byte_t;

  // Protocol address or length field
  typedef logic [63:0] doub_t;

  // Exit code of a finished computation
  typedef logic [31:0] word_t;

  ////////////////////////////////////////////////////////////
  // Protocol byte codes
  ////////////////////////////////////////////////////////////

  localparam byte_t cmd_read_c  = 8'h11;
  localparam byte_t cmd_write_c = 8'h12;
  localparam byte_t cmd_exec_c  = 8'h13;
  localparam byte_t ack_c       = 8'h06;
  localparam byte_t eot_c       = 8'h04;
  localparam byte_t eoc_c       = 8'h14;

  ////////////////////////////////////////////////////////////
  // Field sizes
  ////////////////////////////////////////////////////////////

  // Bytes per address or length field, sent LSB first
  localparam int unsigned AddrBytes = 8;

  // Bytes of the exit code after EOC
  localparam int unsigned CodeBytes = 4;

  // Only the low bits of a length are kept
  localparam int unsigned LenWidth = 16;

endpackage

`default_nettype wire

/* hdl/uart_rx.sv */
/*
  UART receiver, 8 data bits, no parity, one stop bit.
  Emits a one-cycle strobe with the received byte once the stop bit checks out.
*/
`default_nettype none

module uart_rx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_byte_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned CntWidth = $clog2(ClksPerBit);
  localparam int unsigned HalfBit  = ClksPerBit / 2;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e           state_q;
  logic [1:0]          sync_q;
  logic                rx_s;
  logic [CntWidth-1:0] baud_q;
  logic [2:0]          bit_q;
  byte_t               shift_q;
  logic                valid_q;

  // Line after the two-flop synchronizer
  assign rx_s = sync_q[1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q  <= 2'b11;
      state_q <= RX_IDLE;
      baud_q  <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (!rx_s) begin
            state_q <= RX_START;
            baud_q  <= '0;
          end
        end
        // Recheck the line in the middle of the start bit
        RX_START: begin
          if (baud_q == CntWidth'(HalfBit - 1)) begin
            baud_q  <= '0;
            bit_q   <= '0;
            state_q <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            baud_q <= baud_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (baud_q == CntWidth'(ClksPerBit - 1)) begin
            baud_q  <= '0;
            shift_q <= {rx_s, shift_q[7:1]};
            bit_q   <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            baud_q <= baud_q + 1'b1;
          end
        end
        // Low stop bit means a framing error, byte is dropped
        RX_STOP: begin
          if (baud_q == CntWidth'(ClksPerBit - 1)) begin
            baud_q  <= '0;
            valid_q <= rx_s;
            state_q <= RX_IDLE;
          end else begin
            baud_q <= baud_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
/*
  UART transmitter, 8 data bits, no parity, one stop bit.
  A start strobe while idle sends one byte; busy stays high until the stop bit ends.
*/
`default_nettype none

module uart_tx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                tx_start_i,
  input  uart_dbg_pkg::byte_t tx_byte_i,
  output logic                tx_o,
  output logic                tx_busy_o
);

  localparam int unsigned CntWidth = $clog2(ClksPerBit);

  // Stop bit, data LSB first, start bit in bit 0
  logic [9:0]          frame_q;
  logic [CntWidth-1:0] baud_q;
  logic [3:0]          bit_q;
  logic                busy_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      frame_q <= '1;
      baud_q  <= '0;
      bit_q   <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        frame_q <= {1'b1, tx_byte_i, 1'b0};
        baud_q  <= '0;
        bit_q   <= '0;
        busy_q  <= 1'b1;
      end
    end else if (baud_q == CntWidth'(ClksPerBit - 1)) begin
      // Next bit; ones shift in so the line rests high
      baud_q  <= '0;
      frame_q <= {1'b1, frame_q[9:1]};
      bit_q   <= bit_q + 1'b1;
      if (bit_q == 4'd9) begin
        busy_q <= 1'b0;
      end
    end else begin
      baud_q <= baud_q + 1'b1;
    end
  end

  assign tx_o      = frame_q[0];
  assign tx_busy_o = busy_q;

endmodule

`default_nettype wire

/* hdl/dbg_mem.sv */
/*
  Byte-wide RAM behind the debug server.
  One write port and one read port sharing the address; read data is
  registered and appears the cycle after the read enable.
*/
`default_nettype none

module dbg_mem #(
  parameter int unsigned MemDepth = 256
) (
  input  logic                        clk,
  input  logic                        we_i,
  input  logic                        re_i,
  input  logic [$clog2(MemDepth)-1:0] addr_i,
  input  uart_dbg_pkg::byte_t         wdata_i,
  output uart_dbg_pkg::byte_t         rdata_o
);

  import uart_dbg_pkg::*;

  byte_t mem_q [MemDepth];
  byte_t rdata_q;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    // Output holds its value between reads
    if (re_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hdl/uart_dbg_ctrl.sv */
/*
  Command FSM of the UART debug server.
  Decodes ACK, read, write and exec requests from the receiver, drives the
  RAM and sequences every reply byte through the transmitter.
  Pending EOC reports go out only between commands.
*/
`default_nettype none

module uart_dbg_ctrl #(
  parameter int unsigned MemDepth = 256
) (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        rx_valid_i,
  input  uart_dbg_pkg::byte_t         rx_byte_i,
  input  logic                        tx_busy_i,
  output logic                        tx_start_o,
  output uart_dbg_pkg::byte_t         tx_byte_o,
  output logic                        mem_we_o,
  output logic                        mem_re_o,
  output logic [$clog2(MemDepth)-1:0] mem_addr_o,
  output uart_dbg_pkg::byte_t         mem_wdata_o,
  input  uart_dbg_pkg::byte_t         mem_rdata_i,
  output logic                        exec_valid_o,
  output uart_dbg_pkg::doub_t         exec_addr_o,
  input  logic                        eoc_valid_i,
  input  uart_dbg_pkg::word_t         eoc_code_i
);

  import uart_dbg_pkg::*;

  localparam int unsigned AddrWidth = $clog2(MemDepth);
  localparam int unsigned LenBytes  = LenWidth / 8;
  localparam int unsigned CntWidth  = $clog2(AddrBytes);

  typedef enum logic [3:0] {
    S_IDLE,
    S_ADDR,
    S_LEN,
    S_SEND,
    S_WAIT,
    S_EXEC,
    S_WDATA,
    S_RFETCH,
    S_RDATA,
    S_EOT,
    S_EOC
  } state_e;

  state_e               state_q;
  state_e               ret_q;
  logic [CntWidth-1:0]  cnt_q;
  byte_t                cmd_q;
  byte_t                tx_byte_q;
  doub_t                addr_q;
  doub_t                addr_next;
  doub_t                exec_addr_q;
  logic [LenWidth-1:0]  len_q;
  logic [AddrWidth-1:0] mem_addr_q;
  logic                 eoc_pend_q;
  word_t                eoc_code_q;
  word_t                code_sr_q;

  // Address bytes arrive LSB first
  assign addr_next = {rx_byte_i, addr_q[$bits(doub_t)-1:8]};

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign tx_start_o   = (state_q == S_SEND || state_q == S_EXEC) && !tx_busy_i;
  assign tx_byte_o    = tx_byte_q;
  assign exec_valid_o = (state_q == S_EXEC) && !tx_busy_i;
  assign exec_addr_o  = exec_addr_q;
  assign mem_we_o     = (state_q == S_WDATA) && rx_valid_i && (len_q != '0);
  assign mem_wdata_o  = rx_byte_i;
  assign mem_re_o     = (state_q == S_RFETCH) && (len_q != '0);
  assign mem_addr_o   = mem_addr_q;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= S_IDLE;
      ret_q      <= S_IDLE;
      cnt_q      <= '0;
      eoc_pend_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (rx_valid_i) begin
            cmd_q <= rx_byte_i;
            cnt_q <= '0;
            if (rx_byte_i == ack_c) begin
              tx_byte_q <= ack_c;
              ret_q     <= S_IDLE;
              state_q   <= S_SEND;
            end else if (rx_byte_i == cmd_read_c || rx_byte_i == cmd_write_c ||
                         rx_byte_i == cmd_exec_c) begin
              state_q <= S_ADDR;
            end
          end else if (eoc_pend_q) begin
            // Start the EOC report; code bytes follow
            eoc_pend_q <= 1'b0;
            code_sr_q  <= eoc_code_q;
            tx_byte_q  <= eoc_c;
            cnt_q      <= '0;
            ret_q      <= S_EOC;
            state_q    <= S_SEND;
          end
        end
        S_ADDR: begin
          if (rx_valid_i) begin
            addr_q <= addr_next;
            cnt_q  <= cnt_q + 1'b1;
            if (cnt_q == CntWidth'(AddrBytes - 1)) begin
              cnt_q      <= '0;
              mem_addr_q <= addr_next[AddrWidth-1:0];
              if (cmd_q == cmd_exec_c) begin
                exec_addr_q <= addr_next;
                tx_byte_q   <= ack_c;
                state_q     <= S_EXEC;
              end else begin
                state_q <= S_LEN;
              end
            end
          end
        end
        S_LEN: begin
          if (rx_valid_i) begin
            // Upper length bytes are dropped
            if (cnt_q < CntWidth'(LenBytes)) begin
              len_q <= {rx_byte_i, len_q[LenWidth-1:8]};
            end
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CntWidth'(AddrBytes - 1)) begin
              tx_byte_q <= ack_c;
              ret_q     <= (cmd_q == cmd_read_c) ? S_RFETCH : S_WDATA;
              state_q   <= S_SEND;
            end
          end
        end
        S_SEND: begin
          if (!tx_busy_i) begin
            state_q <= S_WAIT;
          end
        end
        // Busy is high here for the whole frame
        S_WAIT: begin
          if (!tx_busy_i) begin
            state_q <= ret_q;
          end
        end
        S_EXEC: begin
          if (!tx_busy_i) begin
            ret_q   <= S_IDLE;
            state_q <= S_WAIT;
          end
        end
        S_WDATA: begin
          if (len_q == '0) begin
            state_q <= S_EOT;
          end else if (rx_valid_i) begin
            mem_addr_q <= mem_addr_q + 1'b1;
            len_q      <= len_q - 1'b1;
          end
        end
        // RAM read issued here, data is valid in S_RDATA
        S_RFETCH: begin
          state_q <= (len_q == '0) ? S_EOT : S_RDATA;
        end
        S_RDATA: begin
          tx_byte_q  <= mem_rdata_i;
          mem_addr_q <= mem_addr_q + 1'b1;
          len_q      <= len_q - 1'b1;
          ret_q      <= S_RFETCH;
          state_q    <= S_SEND;
        end
        S_EOT: begin
          tx_byte_q <= eot_c;
          ret_q     <= S_IDLE;
          state_q   <= S_SEND;
        end
        S_EOC: begin
          tx_byte_q <= code_sr_q[7:0];
          code_sr_q <= code_sr_q >> 8;
          cnt_q     <= cnt_q + 1'b1;
          ret_q     <= (cnt_q == CntWidth'(CodeBytes - 1)) ? S_IDLE : S_EOC;
          state_q   <= S_SEND;
        end
        default: state_q <= S_IDLE;
      endcase

      // Latch a report at any time, sent once idle
      if (eoc_valid_i) begin
        eoc_pend_q <= 1'b1;
        eoc_code_q <= eoc_code_i;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_dbg_top.sv */
/*
  Top level of the UART debug server.
  Connects the serial receiver and transmitter, the command FSM and the byte RAM.
*/
`default_nettype none

module uart_dbg_top #(
  parameter int unsigned ClksPerBit = 16,
  parameter int unsigned MemDepth   = 256
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                uart_rx_i,
  output logic                uart_tx_o,
  output logic                exec_valid_o,
  output uart_dbg_pkg::doub_t exec_addr_o,
  input  logic                eoc_valid_i,
  input  uart_dbg_pkg::word_t eoc_code_i
);

  import uart_dbg_pkg::*;

  localparam int unsigned AddrWidth = $clog2(MemDepth);

  logic                 rx_valid;
  byte_t                rx_byte;
  logic                 tx_start;
  byte_t                tx_byte;
  logic                 tx_busy;
  logic                 mem_we;
  logic                 mem_re;
  logic [AddrWidth-1:0] mem_addr;
  byte_t                mem_wdata;
  byte_t                mem_rdata;

  uart_rx #(
    .ClksPerBit (ClksPerBit)
  ) u_rx (
    .clk        (clk),
    .reset_i    (reset_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  uart_tx #(
    .ClksPerBit (ClksPerBit)
  ) u_tx (
    .clk        (clk),
    .reset_i    (reset_i),
    .tx_start_i (tx_start),
    .tx_byte_i  (tx_byte),
    .tx_o       (uart_tx_o),
    .tx_busy_o  (tx_busy)
  );

  uart_dbg_ctrl #(
    .MemDepth (MemDepth)
  ) u_ctrl (
    .clk          (clk),
    .reset_i      (reset_i),
    .rx_valid_i   (rx_valid),
    .rx_byte_i    (rx_byte),
    .tx_busy_i    (tx_busy),
    .tx_start_o   (tx_start),
    .tx_byte_o    (tx_byte),
    .mem_we_o     (mem_we),
    .mem_re_o     (mem_re),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .exec_valid_o (exec_valid_o),
    .exec_addr_o  (exec_addr_o),
    .eoc_valid_i  (eoc_valid_i),
    .eoc_code_i   (eoc_code_i)
  );

  dbg_mem #(
    .MemDepth (MemDepth)
  ) u_mem (
    .clk     (clk),
    .we_i    (mem_we),
    .re_i    (mem_re),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

/* verif/uart_dbg_asserts.sv */
/*
  Concurrent checks on the ports of the debug server top level.
  Covers the idle line after reset, the exec strobe width and the entry address hold.
*/
`default_nettype none

module uart_dbg_asserts (
  input logic                clk,
  input logic                reset_i,
  input logic                uart_rx_i,
  input logic                uart_tx_o,
  input logic                exec_valid_o,
  input uart_dbg_pkg::doub_t exec_addr_o
);

  int   fail_cnt = 0;
  logic rx_seen_q;

  // Set by the first start bit from the host
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rx_seen_q <= 1'b0;
    end else if (!uart_rx_i) begin
      rx_seen_q <= 1'b1;
    end
  end

  a_tx_idle_in_reset: assert property (@(posedge clk) reset_i |=> uart_tx_o)
    else begin
      fail_cnt++;
      $error("Serial output not idle after reset");
    end

  a_quiet_before_rx: assert property (@(posedge clk) disable iff (reset_i)
    !rx_seen_q |-> uart_tx_o && !exec_valid_o)
    else begin
      fail_cnt++;
      $error("Output activity before any host frame");
    end

  a_exec_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
    exec_valid_o |=> !exec_valid_o)
    else begin
      fail_cnt++;
      $error("Exec strobe longer than one cycle");
    end

  // Entry address only moves together with the strobe
  a_exec_addr_hold: assert property (@(posedge clk) disable iff (reset_i)
    $changed(exec_addr_o) |-> exec_valid_o)
    else begin
      fail_cnt++;
      $error("Exec address changed without a strobe");
    end

endmodule

bind uart_dbg_top uart_dbg_asserts u_asserts (
  .clk          (clk),
  .reset_i      (reset_i),
  .uart_rx_i    (uart_rx_i),
  .uart_tx_o    (uart_tx_o),
  .exec_valid_o (exec_valid_o),
  .exec_addr_o  (exec_addr_o)
);

`default_nettype wire

/* verif/uart_dbg_tb.sv */
/*
  Testbench for the UART debug server.
  Sends host frames on the serial input, decodes every reply frame into a queue
  and checks the replies against the protocol rules. Bound assertions watch the ports.
*/
`default_nettype none

module uart_dbg_tb;

  import uart_dbg_pkg::*;

  localparam int ClksPerBit   = 4;
  localparam int MemDepth     = 256;
  localparam int AddrWidth    = $clog2(MemDepth);
  localparam int ReplyTimeout = 30 * ClksPerBit;

  logic  clk = 1'b0;
  logic  reset_i;
  logic  uart_rx_i;
  logic  uart_tx_o;
  logic  exec_valid_o;
  doub_t exec_addr_o;
  logic  eoc_valid_i;
  word_t eoc_code_i;

  byte_t       tx_q [$];
  byte_t       model_mem [MemDepth];
  logic [31:0] rng_q = 32'h0e266da5;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start_fails = 0;
  string       test_name;
  int          exec_pulses = 0;
  doub_t       exec_seen;

  always #2 clk = ~clk;

  uart_dbg_top #(
    .ClksPerBit (ClksPerBit),
    .MemDepth   (MemDepth)
  ) u_dut (
    .clk          (clk),
    .reset_i      (reset_i),
    .uart_rx_i    (uart_rx_i),
    .uart_tx_o    (uart_tx_o),
    .exec_valid_o (exec_valid_o),
    .exec_addr_o  (exec_addr_o),
    .eoc_valid_i  (eoc_valid_i),
    .eoc_code_i   (eoc_code_i)
  );

  ////////////////////////////////////////////////////////////
  // Reply decoder and exec pulse counter
  ////////////////////////////////////////////////////////////

  // Polls the line one step after each edge, samples mid-bit
  initial begin : tx_monitor
    byte_t rx_b;
    forever begin
      @(posedge clk);
      #1;
      if (!reset_i && !uart_tx_o) begin
        repeat (ClksPerBit / 2) @(posedge clk);
        for (int k = 0; k < 8; k++) begin
          repeat (ClksPerBit) @(posedge clk);
          #1;
          rx_b = {uart_tx_o, rx_b[7:1]};
        end
        repeat (ClksPerBit) @(posedge clk);
        #1;
        if (!uart_tx_o) begin
          errors++;
          $display("Reply frame at %0t had a low stop bit", $time);
        end else begin
          tx_q.push_back(rx_b);
        end
      end
    end
  end

  always @(negedge clk) begin
    if (exec_valid_o) begin
      exec_pulses++;
      exec_seen = exec_addr_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  function automatic int fail_total();
    return errors + u_dut.u_asserts.fail_cnt;
  endfunction

  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int k = 0; k < 10; k++) begin
      @(posedge clk);
      #1;
      uart_rx_i = frame[0];
      frame = frame >> 1;
      repeat (ClksPerBit - 1) @(posedge clk);
    end
  endtask

  // Eight bytes, LSB first
  task automatic send_field(input doub_t v);
    doub_t sh;
    sh = v;
    for (int k = 0; k < AddrBytes; k++) begin
      send_byte(sh[7:0]);
      sh = sh >> 8;
    end
  endtask

  task automatic expect_byte(input byte_t exp, input string what);
    int    waited;
    byte_t got;
    waited = 0;
    while (tx_q.size() == 0 && waited < ReplyTimeout) begin
      @(posedge clk);
      waited++;
    end
    if (tx_q.size() == 0) begin
      errors++;
      $display("No reply byte for %s within %0d cycles", what, ReplyTimeout);
    end else begin
      got = tx_q.pop_front();
      assert (got == exp) else begin
        errors++;
        $display("FAILED at %0t: %s is 8'h%02h, expected 8'h%02h", $time, what, got, exp);
      end
    end
  endtask

  // Line must stay silent for the whole window
  task automatic wait_quiet(input string what);
    repeat (ReplyTimeout) @(posedge clk);
    #1;
    assert (tx_q.size() == 0 && uart_tx_o) else begin
      errors++;
      $display("Unexpected reply traffic after %s", what);
      tx_q.delete();
    end
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_start_fails = fail_total();
  endtask

  task automatic close_test();
    int delta;
    delta = fail_total() - test_start_fails;
    tests_run++;
    if (delta != 0) begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", test_name, delta);
    end else begin
      $display("Test %s: ok", test_name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic write_then_read();
    byte_t                data [$];
    doub_t                addr;
    doub_t                len;
    int                   n;
    logic [AddrWidth-1:0] idx;
    n = 8 + int'(next_rand() & 32'h7);
    // Start near the top of the RAM so the burst wraps
    addr = {next_rand(), next_rand()};
    addr[AddrWidth-1:0] = AddrWidth'(MemDepth - 4);
    len = {next_rand(), next_rand()};
    len[LenWidth-1:0] = LenWidth'(n);
    send_byte(cmd_write_c);
    send_field(addr);
    send_field(len);
    expect_byte(ack_c, "write ACK");
    for (int i = 0; i < n; i++) begin
      data.push_back(byte_t'(next_rand()));
      idx = addr[AddrWidth-1:0] + AddrWidth'(i);
      model_mem[idx] = data[i];
      send_byte(data[i]);
    end
    expect_byte(eot_c, "write EOT");
    send_byte(cmd_read_c);
    send_field(addr);
    send_field(len);
    expect_byte(ack_c, "read ACK");
    for (int i = 0; i < n; i++) begin
      idx = addr[AddrWidth-1:0] + AddrWidth'(i);
      expect_byte(model_mem[idx], "read data");
    end
    expect_byte(eot_c, "read EOT");
    // Same bytes seen through address zero with other upper bits
    addr = {next_rand(), next_rand()};
    addr[AddrWidth-1:0] = '0;
    len = '0;
    len[LenWidth-1:0] = LenWidth'(n - 4);
    send_byte(cmd_read_c);
    send_field(addr);
    send_field(len);
    expect_byte(ack_c, "wrapped read ACK");
    for (int i = 0; i < n - 4; i++) begin
      idx = AddrWidth'(i);
      expect_byte(model_mem[idx], "wrapped read data");
    end
    expect_byte(eot_c, "wrapped read EOT");
  endtask

  task automatic exec_entry();
    doub_t addr;
    int    pulses_before;
    addr = {next_rand(), next_rand()};
    pulses_before = exec_pulses;
    send_byte(cmd_exec_c);
    send_field(addr);
    expect_byte(ack_c, "exec ACK");
    assert (exec_pulses == pulses_before + 1) else begin
      errors++;
      $display("FAILED at %0t: %0d exec pulses, expected one", $time,
               exec_pulses - pulses_before);
    end
    assert (exec_seen == addr) else begin
      errors++;
      $display("FAILED at %0t: exec address 64'h%016h, expected 64'h%016h", $time,
               exec_seen, addr);
    end
  endtask

  task automatic eoc_report();
    word_t code;
    code = next_rand();
    @(posedge clk);
    #1;
    eoc_valid_i = 1'b1;
    eoc_code_i  = code;
    @(posedge clk);
    #1;
    eoc_valid_i = 1'b0;
    expect_byte(eoc_c, "EOC byte");
    for (int k = 0; k < CodeBytes; k++) begin
      expect_byte(code[7:0], "exit code byte");
      code = code >> 8;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset_i     = 1'b1;
    uart_rx_i   = 1'b1;
    eoc_valid_i = 1'b0;
    eoc_code_i  = '0;
    repeat (4) @(posedge clk);
    #1;
    reset_i = 1'b0;

    open_test("reset_idle");
    repeat (20) @(posedge clk);
    close_test();

    open_test("ack_challenge");
    send_byte(ack_c);
    expect_byte(ack_c, "ACK echo");
    wait_quiet("ACK echo");
    close_test();

    open_test("write_then_read");
    write_then_read();
    close_test();

    open_test("exec_entry");
    exec_entry();
    close_test();

    open_test("eoc_report");
    eoc_report();
    close_test();

    open_test("unknown_command");
    send_byte(8'h5a);
    wait_quiet("unknown command byte");
    send_byte(ack_c);
    expect_byte(ack_c, "ACK after unknown command");
    close_test();

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             tests_run, tests_failed, fail_total());
    if (fail_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_dbg_top.f */
hdl/uart_dbg_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/dbg_mem.sv
hdl/uart_dbg_ctrl.sv
hdl/uart_dbg_top.sv
verif/uart_dbg_asserts.sv
verif/uart_dbg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the UART debug server testbench with Verilator and run it
LOG=sim.log

verilator --binary --timing --assert --top-module uart_dbg_tb \
  -f uart_dbg_top.f --Mdir obj_dir -o uart_dbg_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/uart_dbg_sim +verilator+error+limit+100 > "$LOG" 2>&1 \
  || echo "Simulator exited with an error status"
cat "$LOG"

grep -q "All tests passed!" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }
